//--- cache_defs.svh
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// byte address and data widths
`define ADDR_WIDTH 12
`define WORD_WIDTH 32
`define HALF_WIDTH 16
`define BYTE_WIDTH 8

// cache geometry
`define LINE_BYTES 16
`define NUM_LINES 8
`define LINE_WIDTH (`LINE_BYTES * `BYTE_WIDTH)
`define LINE_ADDR_WIDTH (`ADDR_WIDTH - $clog2(`LINE_BYTES))
`define WORD_BYTES (`WORD_WIDTH / `BYTE_WIDTH)
`define WORD_ADDR_WIDTH (`ADDR_WIDTH - $clog2(`WORD_BYTES))

// pending stores held ahead of the line array
`define SB_DEPTH 4

// backing store timing and initial contents
`define MEM_LATENCY 4
`define MEM_PATTERN 32'h5a3c_96e1

`endif

//--- cache_pkg.sv
`include "cache_defs.svh"

package cache_pkg;

    // access size of a cpu request
    typedef enum logic [1:0] {
        BYTE,
        HALF,
        WORD
    } access_mode_e;

    // per-line state
    typedef enum logic [1:0] {
        INVALID,
        VALID,
        REQUESTED
    } line_state_e;

    typedef enum logic {
        IDLE,
        PUSH
    } sb_op_e;

    // write data right-aligned for byte and half
    typedef struct packed {
        logic                    read;
        logic                    write;
        access_mode_e            mode;
        logic [`ADDR_WIDTH-1:0]  addr;
        logic [`WORD_WIDTH-1:0]  data;
    } cpu_request_t;

    typedef struct packed {
        logic                    hit;
        logic [`WORD_WIDTH-1:0]  data;
    } cpu_response_t;

    // whole-line transfers to and from main memory
    typedef struct packed {
        logic                         read;
        logic                         write;
        logic [`LINE_ADDR_WIDTH-1:0]  addr;
        logic [`LINE_WIDTH-1:0]       data;
    } mem_request_t;

    typedef struct packed {
        logic                         valid;
        logic [`LINE_ADDR_WIDTH-1:0]  addr;
        logic [`LINE_WIDTH-1:0]       data;
    } mem_response_t;

endpackage

//--- store_buffer.sv
`timescale 1ns/1ps
`include "cache_defs.svh"

module store_buffer (
    input  logic                          clock,
    input  logic                          reset,
    input  cache_pkg::sb_op_e             operation,
    input  cache_pkg::access_mode_e       mode,
    input  logic                          pop,
    input  logic [`ADDR_WIDTH-1:0]        tag_in,
    input  logic [`WORD_WIDTH-1:0]        data_in,
    output logic [`WORD_ADDR_WIDTH-1:0]   tag_pop,
    output logic [`WORD_WIDTH-1:0]        data_pop,
    output logic [`WORD_BYTES-1:0]        byte_enable_pop,
    output logic                          empty,
    output logic                          full,
    output logic [`NUM_LINES-1:0]         hit_lines,
    output logic [`WORD_BYTES-1:0]        forward_bytes,
    output logic [`WORD_WIDTH-1:0]        forward_data
);
    localparam int PTR_BITS = $clog2(`SB_DEPTH);
    localparam int BYTE_BITS = $clog2(`WORD_BYTES);
    localparam int WORD_SEL_BITS = $clog2(`LINE_BYTES) - BYTE_BITS;
    localparam int INDEX_BITS = $clog2(`NUM_LINES);
    localparam int HALF_BYTES = `HALF_WIDTH / `BYTE_WIDTH;

    typedef struct packed {
        logic [`WORD_ADDR_WIDTH-1:0]  word_addr;
        logic [`WORD_WIDTH-1:0]       data;
        logic [`WORD_BYTES-1:0]       byte_enable;
    } entry_t;

    entry_t               entries [`SB_DEPTH];
    entry_t               new_entry;
    logic [PTR_BITS-1:0]  head;
    logic [PTR_BITS-1:0]  tail;
    logic [PTR_BITS:0]    count;
    logic                 push;

    assign push = operation == cache_pkg::PUSH;

    // data replicated across the word, enables pick the lanes
    always_comb begin
        new_entry.word_addr = tag_in[`ADDR_WIDTH-1:BYTE_BITS];
        case (mode)
            cache_pkg::BYTE: begin
                new_entry.data = {`WORD_BYTES{data_in[`BYTE_WIDTH-1:0]}};
                new_entry.byte_enable = {{(`WORD_BYTES-1){1'b0}}, 1'b1} << tag_in[BYTE_BITS-1:0];
            end
            cache_pkg::HALF: begin
                new_entry.data = {(`WORD_WIDTH / `HALF_WIDTH){data_in[`HALF_WIDTH-1:0]}};
                new_entry.byte_enable = {{(`WORD_BYTES-HALF_BYTES){1'b0}}, {HALF_BYTES{1'b1}}}
                    << {tag_in[BYTE_BITS-1:1], 1'b0};
            end
            default: begin
                new_entry.data = data_in;
                new_entry.byte_enable = '1;
            end
        endcase
    end

    // walk oldest to newest so the newest store wins each byte
    always_comb begin
        logic [PTR_BITS-1:0] slot;
        forward_bytes = '0;
        forward_data = '0;
        hit_lines = '0;
        for (int i = 0; i < `SB_DEPTH; i++) begin
            slot = head + PTR_BITS'(i);
            if (i < int'(count)) begin
                hit_lines[entries[slot].word_addr[WORD_SEL_BITS +: INDEX_BITS]] = 1'b1;
                if (entries[slot].word_addr == tag_in[`ADDR_WIDTH-1:BYTE_BITS]) begin
                    for (int b = 0; b < `WORD_BYTES; b++) begin
                        if (entries[slot].byte_enable[b]) begin
                            forward_bytes[b] = 1'b1;
                            forward_data[b*`BYTE_WIDTH +: `BYTE_WIDTH] =
                                entries[slot].data[b*`BYTE_WIDTH +: `BYTE_WIDTH];
                        end
                    end
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (push) begin
            entries[tail] <= new_entry;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head <= '0;
            tail <= '0;
            count <= '0;
        end else begin
            if (push) begin
                tail <= tail + 1'b1;
            end
            if (pop) begin
                head <= head + 1'b1;
            end
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign tag_pop = entries[head].word_addr;
    assign data_pop = entries[head].data;
    assign byte_enable_pop = entries[head].byte_enable;
    assign empty = count == '0;
    assign full = count == (PTR_BITS+1)'(`SB_DEPTH);

    // the cache must respect full and empty
    a_no_overflow_underflow: assert property (@(posedge clock) disable iff (reset)
        !(push && full) && !(pop && empty));

endmodule

//--- line_cache.sv
`timescale 1ns/1ps
`include "cache_defs.svh"

module line_cache (
    input  logic                      clock,
    input  logic                      reset,
    input  cache_pkg::cpu_request_t   cpu_request,
    output cache_pkg::cpu_response_t  cpu_response,
    input  logic                      mem_available,
    output cache_pkg::mem_request_t   mem_request,
    input  cache_pkg::mem_response_t  mem_response
);
    localparam int OFFSET_BITS = $clog2(`LINE_BYTES);
    localparam int INDEX_BITS = $clog2(`NUM_LINES);
    localparam int BYTE_BITS = $clog2(`WORD_BYTES);
    localparam int WORD_SEL_BITS = OFFSET_BITS - BYTE_BITS;
    localparam int HALF_BYTES = `HALF_WIDTH / `BYTE_WIDTH;

    cache_pkg::line_state_e        line_states  [`NUM_LINES];
    logic [`LINE_BYTES-1:0]        line_dirties [`NUM_LINES];
    logic [`LINE_ADDR_WIDTH-1:0]   line_addrs   [`NUM_LINES];
    logic [`LINE_WIDTH-1:0]        line_datas   [`NUM_LINES];

    logic [`LINE_ADDR_WIDTH-1:0]   req_line_addr;
    logic [INDEX_BITS-1:0]         index;
    logic [WORD_SEL_BITS-1:0]      word_sel;
    logic [BYTE_BITS-1:0]          byte_sel;
    cache_pkg::line_state_e        state;
    logic                          line_present;
    logic                          line_dirty;

    assign req_line_addr = cpu_request.addr[`ADDR_WIDTH-1:OFFSET_BITS];
    assign index = req_line_addr[INDEX_BITS-1:0];
    assign word_sel = cpu_request.addr[BYTE_BITS +: WORD_SEL_BITS];
    assign byte_sel = cpu_request.addr[BYTE_BITS-1:0];
    assign state = line_states[index];
    assign line_present = state != cache_pkg::INVALID && line_addrs[index] == req_line_addr;
    assign line_dirty = |line_dirties[index];

    cache_pkg::sb_op_e             sb_operation;
    logic                          sb_pop;
    logic                          sb_empty;
    logic                          sb_full;
    logic [`WORD_ADDR_WIDTH-1:0]   sb_tag_pop;
    logic [`WORD_WIDTH-1:0]        sb_data_pop;
    logic [`WORD_BYTES-1:0]        sb_byte_enable_pop;
    logic [`NUM_LINES-1:0]         sb_hit_lines;
    logic [`WORD_BYTES-1:0]        sb_forward_bytes;
    logic [`WORD_WIDTH-1:0]        sb_forward_data;
    logic                          write_hit;

    // stores may land on a line still being fetched
    assign write_hit = cpu_request.write && !sb_full && line_present;
    assign sb_operation = write_hit ? cache_pkg::PUSH : cache_pkg::IDLE;
    // an arriving line owns the array for that cycle
    assign sb_pop = !sb_empty && !mem_response.valid;

    store_buffer store_buffer_inst (
        .clock           (clock),
        .reset           (reset),
        .operation       (sb_operation),
        .mode            (cpu_request.mode),
        .pop             (sb_pop),
        .tag_in          (cpu_request.addr),
        .data_in         (cpu_request.data),
        .tag_pop         (sb_tag_pop),
        .data_pop        (sb_data_pop),
        .byte_enable_pop (sb_byte_enable_pop),
        .empty           (sb_empty),
        .full            (sb_full),
        .hit_lines       (sb_hit_lines),
        .forward_bytes   (sb_forward_bytes),
        .forward_data    (sb_forward_data)
    );

    logic [`WORD_WIDTH-1:0]        bank_word;
    logic [`WORD_BYTES-1:0]        bank_bytes;
    logic [`WORD_BYTES-1:0]        covered_bytes;
    logic [`WORD_WIDTH-1:0]        merged_word;
    logic                          covered;
    logic                          read_hit;

    assign bank_word = line_datas[index][word_sel*`WORD_WIDTH +: `WORD_WIDTH];
    // a requested line only trusts its own dirty bytes
    assign bank_bytes = {`WORD_BYTES{state == cache_pkg::VALID}}
        | ({`WORD_BYTES{state == cache_pkg::REQUESTED}}
           & line_dirties[index][word_sel*`WORD_BYTES +: `WORD_BYTES]);
    assign covered_bytes = bank_bytes | sb_forward_bytes;

    always_comb begin
        for (int b = 0; b < `WORD_BYTES; b++) begin
            merged_word[b*`BYTE_WIDTH +: `BYTE_WIDTH] = sb_forward_bytes[b]
                ? sb_forward_data[b*`BYTE_WIDTH +: `BYTE_WIDTH]
                : bank_word[b*`BYTE_WIDTH +: `BYTE_WIDTH];
        end
    end

    always_comb begin
        case (cpu_request.mode)
            cache_pkg::BYTE: covered = covered_bytes[byte_sel];
            cache_pkg::HALF: covered = &covered_bytes[byte_sel[BYTE_BITS-1:1]*HALF_BYTES +: HALF_BYTES];
            default: covered = &covered_bytes;
        endcase
    end

    assign read_hit = line_present && covered;

    // zero-extended, right-aligned read data
    always_comb begin
        cpu_response.hit = (cpu_request.read && read_hit) || write_hit;
        case (cpu_request.mode)
            cache_pkg::BYTE:
                cpu_response.data = `WORD_WIDTH'(merged_word[byte_sel*`BYTE_WIDTH +: `BYTE_WIDTH]);
            cache_pkg::HALF:
                cpu_response.data =
                    `WORD_WIDTH'(merged_word[byte_sel[BYTE_BITS-1:1]*`HALF_WIDTH +: `HALF_WIDTH]);
            default: cpu_response.data = merged_word;
        endcase
    end

    logic need_line;
    logic no_pending;

    assign need_line = (cpu_request.read || cpu_request.write) && !line_present;
    assign no_pending = !sb_hit_lines[index];

    always_comb begin
        mem_request.read = mem_available && need_line && (state == cache_pkg::INVALID
            || (state == cache_pkg::VALID && !line_dirty && no_pending));
        mem_request.write = mem_available && need_line
            && state == cache_pkg::VALID && line_dirty && no_pending;
        mem_request.addr = mem_request.read ? req_line_addr : line_addrs[index];
        mem_request.data = line_datas[index];
    end

    logic [`LINE_ADDR_WIDTH-1:0]   pop_line_addr;
    logic [INDEX_BITS-1:0]         pop_index;
    logic [WORD_SEL_BITS-1:0]      pop_word;
    logic [INDEX_BITS-1:0]         resp_index;

    assign pop_line_addr = sb_tag_pop[`WORD_ADDR_WIDTH-1:WORD_SEL_BITS];
    assign pop_index = pop_line_addr[INDEX_BITS-1:0];
    assign pop_word = sb_tag_pop[WORD_SEL_BITS-1:0];
    assign resp_index = mem_response.addr[INDEX_BITS-1:0];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `NUM_LINES; i++) begin
                line_states[i] <= cache_pkg::INVALID;
                line_dirties[i] <= '0;
            end
        end else begin
            if (mem_request.read) begin
                line_states[index] <= cache_pkg::REQUESTED;
                line_addrs[index] <= req_line_addr;
            end else if (mem_request.write) begin
                // victim is now in memory, slot is free
                line_states[index] <= cache_pkg::INVALID;
                line_dirties[index] <= '0;
            end
            if (mem_response.valid) begin
                // keep bytes written while the fetch was in flight
                for (int b = 0; b < `LINE_BYTES; b++) begin
                    if (!line_dirties[resp_index][b]) begin
                        line_datas[resp_index][b*`BYTE_WIDTH +: `BYTE_WIDTH] <=
                            mem_response.data[b*`BYTE_WIDTH +: `BYTE_WIDTH];
                    end
                end
                line_states[resp_index] <= cache_pkg::VALID;
            end
            if (sb_pop) begin
                for (int b = 0; b < `WORD_BYTES; b++) begin
                    if (sb_byte_enable_pop[b]) begin
                        line_dirties[pop_index][pop_word*`WORD_BYTES + b] <= 1'b1;
                        line_datas[pop_index][(pop_word*`WORD_BYTES + b)*`BYTE_WIDTH +: `BYTE_WIDTH]
                            <= sb_data_pop[b*`BYTE_WIDTH +: `BYTE_WIDTH];
                    end
                end
            end
        end
    end

    // a returning line lands only in a slot waiting for it
    a_response_to_requested: assert property (@(posedge clock) disable iff (reset)
        mem_response.valid |-> line_states[resp_index] == cache_pkg::REQUESTED);

    // drained stores belong to the line still held in their slot
    a_pop_to_owned_line: assert property (@(posedge clock) disable iff (reset)
        sb_pop |-> line_states[pop_index] != cache_pkg::INVALID
                   && line_addrs[pop_index] == pop_line_addr);

endmodule

//--- main_memory.sv
`timescale 1ns/1ps
`include "cache_defs.svh"

module main_memory (
    input  logic                      clock,
    input  logic                      reset,
    input  cache_pkg::mem_request_t   mem_request,
    output logic                      mem_available,
    output cache_pkg::mem_response_t  mem_response
);
    localparam int MEM_LINES = 2 ** `LINE_ADDR_WIDTH;
    localparam int LINE_WORDS = `LINE_BYTES / `WORD_BYTES;
    localparam int TIMER_BITS = $clog2(`MEM_LATENCY + 1);

    logic [`LINE_WIDTH-1:0]        lines [MEM_LINES];
    logic [TIMER_BITS-1:0]         timer;
    logic [`LINE_ADDR_WIDTH-1:0]   pending_addr;
    logic                          resp_valid;
    logic [`LINE_WIDTH-1:0]        resp_data;

    // each aligned word starts as its byte address xor the pattern
    initial begin
        for (int l = 0; l < MEM_LINES; l++) begin
            for (int w = 0; w < LINE_WORDS; w++) begin
                lines[l][w*`WORD_WIDTH +: `WORD_WIDTH] =
                    (l * `LINE_BYTES + w * `WORD_BYTES) ^ `MEM_PATTERN;
            end
        end
    end

    // write-backs commit at once
    always @(posedge clock) begin
        if (mem_request.write) begin
            lines[mem_request.addr] <= mem_request.data;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            timer <= '0;
            resp_valid <= 1'b0;
        end else begin
            // valid rises as the countdown reaches zero
            resp_valid <= timer == TIMER_BITS'(1);
            if (mem_request.read) begin
                timer <= TIMER_BITS'(`MEM_LATENCY);
            end else if (timer != '0) begin
                timer <= timer - 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (mem_request.read) begin
            pending_addr <= mem_request.addr;
        end
        if (timer == TIMER_BITS'(1)) begin
            resp_data <= lines[pending_addr];
        end
    end

    // busy from the fetch strobe through the response cycle
    assign mem_available = timer == '0 && !resp_valid;
    assign mem_response.valid = resp_valid;
    assign mem_response.addr = pending_addr;
    assign mem_response.data = resp_data;

    a_no_strobe_while_busy: assert property (@(posedge clock) disable iff (reset)
        (mem_request.read || mem_request.write) |-> timer == '0 && !resp_valid);

endmodule

//--- cache_top.sv
`timescale 1ns/1ps

module cache_top (
    input  logic                      clock,
    input  logic                      reset,
    input  cache_pkg::cpu_request_t   cpu_request,
    output cache_pkg::cpu_response_t  cpu_response
);
    cache_pkg::mem_request_t   mem_request;
    cache_pkg::mem_response_t  mem_response;
    logic                      mem_available;

    line_cache line_cache_inst (
        .clock         (clock),
        .reset         (reset),
        .cpu_request   (cpu_request),
        .cpu_response  (cpu_response),
        .mem_available (mem_available),
        .mem_request   (mem_request),
        .mem_response  (mem_response)
    );

    // line-wide backing store behind the cache
    main_memory main_memory_inst (
        .clock         (clock),
        .reset         (reset),
        .mem_request   (mem_request),
        .mem_available (mem_available),
        .mem_response  (mem_response)
    );

endmodule

//--- tb_cache.sv
`timescale 1ns/1ps
`include "cache_defs.svh"

module tb_cache;
    localparam int REF_BYTES = 2 ** `ADDR_WIDTH;
    // bound on one access covering drain, write-back and fetch with slack
    localparam int ACCESS_LIMIT = `SB_DEPTH + `MEM_LATENCY + 8;
    localparam int DIRECTED_ACCESSES = 80;
    localparam int RANDOM_OPS = 200;
    localparam int RUN_LIMIT = (DIRECTED_ACCESSES + RANDOM_OPS) * ACCESS_LIMIT + 3;

    logic                      clock;
    logic                      reset;
    cache_pkg::cpu_request_t   cpu_request;
    cache_pkg::cpu_response_t  cpu_response;

    // byte-wide reference image of main memory
    logic [`BYTE_WIDTH-1:0]    ref_mem [REF_BYTES];
    int                        errors;
    int                        checks;
    int                        cycles;
    int                        seed;

    cache_top cache_top_inst (
        .clock        (clock),
        .reset        (reset),
        .cpu_request  (cpu_request),
        .cpu_response (cpu_response)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles == RUN_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", RUN_LIMIT);
            $display("Done: errors found");
            $finish;
        end
    end

    task automatic init_reference();
        logic [`WORD_WIDTH-1:0] word;
        for (int a = 0; a < REF_BYTES; a++) begin
            word = `WORD_WIDTH'(a - a % `WORD_BYTES) ^ `MEM_PATTERN;
            ref_mem[`ADDR_WIDTH'(a)] = word[(a % `WORD_BYTES) * `BYTE_WIDTH +: `BYTE_WIDTH];
        end
    endtask

    function automatic logic [`ADDR_WIDTH-1:0] align_address(
        input logic [`ADDR_WIDTH-1:0] addr, input cache_pkg::access_mode_e mode);
        case (mode)
            cache_pkg::BYTE: return addr;
            cache_pkg::HALF: return {addr[`ADDR_WIDTH-1:1], 1'b0};
            default: return {addr[`ADDR_WIDTH-1:2], 2'b00};
        endcase
    endfunction

    function automatic int access_bytes(input cache_pkg::access_mode_e mode);
        case (mode)
            cache_pkg::BYTE: return 1;
            cache_pkg::HALF: return 2;
            default: return 4;
        endcase
    endfunction

    // little-endian gather with zero extension
    function automatic logic [`WORD_WIDTH-1:0] expected_read(
        input logic [`ADDR_WIDTH-1:0] addr, input cache_pkg::access_mode_e mode);
        logic [`WORD_WIDTH-1:0]  value;
        logic [`ADDR_WIDTH-1:0]  base;
        value = '0;
        base = align_address(addr, mode);
        for (int b = 0; b < access_bytes(mode); b++) begin
            value[b*`BYTE_WIDTH +: `BYTE_WIDTH] = ref_mem[base + `ADDR_WIDTH'(b)];
        end
        return value;
    endfunction

    task automatic check_value(input string name, input logic [`WORD_WIDTH-1:0] expected,
                               input logic [`WORD_WIDTH-1:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // drives the request at the next edge and looks for hit at each negedge
    task automatic access(input string name, input logic is_write,
                          input cache_pkg::access_mode_e mode,
                          input logic [`ADDR_WIDTH-1:0] addr,
                          input logic [`WORD_WIDTH-1:0] data,
                          output logic [`WORD_WIDTH-1:0] read_data,
                          output int wait_cycles);
        cache_pkg::cpu_request_t req;
        int waited;
        req.read = !is_write;
        req.write = is_write;
        req.mode = mode;
        req.addr = addr;
        req.data = data;
        waited = 0;
        @(posedge clock);
        cpu_request <= req;
        @(negedge clock);
        while (!cpu_response.hit && waited < ACCESS_LIMIT) begin
            waited++;
            @(negedge clock);
        end
        read_data = cpu_response.data;
        wait_cycles = waited;
        checks++;
        assert (cpu_response.hit) else begin
            errors++;
            $display("ERROR %s: no hit within %0d cycles for address %h",
                     name, ACCESS_LIMIT, addr);
        end
    endtask

    task automatic release_request();
        @(posedge clock);
        cpu_request <= '0;
    endtask

    task automatic read_check(input string name, input cache_pkg::access_mode_e mode,
                              input logic [`ADDR_WIDTH-1:0] addr);
        logic [`WORD_WIDTH-1:0] got;
        logic [`WORD_WIDTH-1:0] expected;
        int waited;
        expected = expected_read(addr, mode);
        access(name, 1'b0, mode, addr, '0, got, waited);
        check_value(name, expected, got);
    endtask

    task automatic write_access(input string name, input cache_pkg::access_mode_e mode,
                                input logic [`ADDR_WIDTH-1:0] addr,
                                input logic [`WORD_WIDTH-1:0] data);
        logic [`WORD_WIDTH-1:0]  got;
        logic [`ADDR_WIDTH-1:0]  base;
        int waited;
        access(name, 1'b1, mode, addr, data, got, waited);
        base = align_address(addr, mode);
        for (int b = 0; b < access_bytes(mode); b++) begin
            ref_mem[base + `ADDR_WIDTH'(b)] = data[b*`BYTE_WIDTH +: `BYTE_WIDTH];
        end
    endtask

    task automatic test_cold_read();
        logic [`WORD_WIDTH-1:0]  got;
        logic [`ADDR_WIDTH-1:0]  addr;
        int waited;
        addr = 12'h1a4;
        access("cold_read", 1'b0, cache_pkg::WORD, addr, '0, got, waited);
        checks++;
        assert (waited > 0) else begin
            errors++;
            $display("ERROR cold_read: first read of %h hit without a fetch", addr);
        end
        check_value("cold_read", `WORD_WIDTH'(addr) ^ `MEM_PATTERN, got);
        access("cold_reread", 1'b0, cache_pkg::WORD, addr, '0, got, waited);
        checks++;
        assert (waited == 0) else begin
            errors++;
            $display("ERROR cold_reread: repeat read of %h missed in its first cycle", addr);
        end
        check_value("cold_reread", `WORD_WIDTH'(addr) ^ `MEM_PATTERN, got);
        release_request();
    endtask

    task automatic test_sized_writes();
        logic [`ADDR_WIDTH-1:0] base;
        base = 12'h040;
        read_check("sized_fill", cache_pkg::WORD, base);
        // each read follows its write while the store is still buffered
        write_access("sized_write_byte", cache_pkg::BYTE, base + 12'h1, 32'h0000_00a5);
        read_check("sized_fwd_byte", cache_pkg::BYTE, base + 12'h1);
        write_access("sized_write_half", cache_pkg::HALF, base + 12'h6, 32'h0000_beef);
        read_check("sized_fwd_half", cache_pkg::HALF, base + 12'h6);
        read_check("sized_fwd_word", cache_pkg::WORD, base + 12'h4);
        write_access("sized_write_word", cache_pkg::WORD, base + 12'h8, 32'hcafe_f00d);
        read_check("sized_word_byte", cache_pkg::BYTE, base + 12'hb);
        read_check("sized_word_half", cache_pkg::HALF, base + 12'ha);
        read_check("sized_word_word", cache_pkg::WORD, base + 12'h8);
        for (int off = 0; off < `LINE_BYTES; off++) begin
            read_check("sized_read_byte", cache_pkg::BYTE, base + `ADDR_WIDTH'(off));
        end
        for (int off = 0; off < `LINE_BYTES; off += 2) begin
            read_check("sized_read_half", cache_pkg::HALF, base + `ADDR_WIDTH'(off));
        end
        for (int off = 0; off < `LINE_BYTES; off += 4) begin
            read_check("sized_read_word", cache_pkg::WORD, base + `ADDR_WIDTH'(off));
        end
        release_request();
    endtask

    task automatic test_write_miss();
        logic [`ADDR_WIDTH-1:0] base;
        base = 12'h2c0;
        write_access("miss_write", cache_pkg::HALF, base + 12'h6, 32'h0000_7e57);
        for (int off = 0; off < `LINE_BYTES; off++) begin
            read_check("miss_read", cache_pkg::BYTE, base + `ADDR_WIDTH'(off));
        end
        release_request();
    endtask

    // conflicting address with the same index and another tag
    task automatic test_dirty_eviction();
        write_access("evict_write", cache_pkg::WORD, 12'h104, 32'h1357_9bdf);
        read_check("evict_conflict", cache_pkg::WORD, 12'h184);
        read_check("evict_reread", cache_pkg::WORD, 12'h104);
        read_check("evict_neighbour", cache_pkg::WORD, 12'h108);
        release_request();
    endtask

    task automatic test_saturation();
        logic [`ADDR_WIDTH-1:0] addr;
        for (int i = 0; i < `SB_DEPTH + 2; i++) begin
            addr = 12'h3c0 + `ADDR_WIDTH'(i * `WORD_BYTES);
            write_access("burst_write", cache_pkg::WORD, addr, $random(seed));
        end
        for (int i = 0; i < `SB_DEPTH + 2; i++) begin
            addr = 12'h3c0 + `ADDR_WIDTH'(i * `WORD_BYTES);
            read_check("burst_read", cache_pkg::WORD, addr);
        end
        release_request();
    endtask

    task automatic test_random_mix();
        logic [`WORD_WIDTH-1:0]   pick;
        logic [`WORD_WIDTH-1:0]   offset;
        logic [`WORD_WIDTH-1:0]   coin;
        logic [`ADDR_WIDTH-1:0]   addr;
        cache_pkg::access_mode_e  mode;
        for (int i = 0; i < RANDOM_OPS; i++) begin
            pick = $unsigned($random(seed)) % 3;
            mode = cache_pkg::access_mode_e'(pick[1:0]);
            offset = $random(seed);
            coin = $random(seed);
            addr = align_address(12'h200 + {4'h0, offset[7:0]}, mode);
            if (coin[0]) begin
                write_access("random_write", mode, addr, $random(seed));
            end else begin
                read_check("random_read", mode, addr);
            end
        end
        release_request();
    endtask

    initial begin
        errors = 0;
        checks = 0;
        cycles = 0;
        seed = 32'h80d9407e;
        reset = 1'b1;
        cpu_request = '0;
        init_reference();
        repeat (3) @(posedge clock);
        reset <= 1'b0;
        test_cold_read();
        test_sized_writes();
        test_write_miss();
        test_dirty_eviction();
        test_saturation();
        test_random_mix();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- all.f
+incdir+.
cache_pkg.sv
store_buffer.sv
line_cache.sv
main_memory.sv
cache_top.sv
tb_cache.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_cache
FILE_LIST ?= all.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
JOBS ?= 0
VFLAGS ?= --binary --timing --assert -j $(JOBS)
PASS_TEXT ?= Done: no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
